// ==== flash_pkg.sv ====
//////////////////////////////////////////////////
// shared widths, timing and types for the flash
// boot-ROM controller. imported by the RTL blocks
// and the byte-stream interface
//////////////////////////////////////////////////

package flash_pkg;

  //////////////////////////////////////////////////
  // flash side
  //////////////////////////////////////////////////

  localparam int FAW = 22;            // flash address width
  localparam int FDW = 8;             // flash data width

  //////////////////////////////////////////////////
  // qmem side
  //////////////////////////////////////////////////

  localparam int QAW = 22;            // qmem byte address width
  localparam int QDW = 32;            // qmem data width
  localparam int QSW = 4;             // qmem select width

  localparam int BYTES_PER_WORD = QDW / FDW;  // flash reads per word

  // clocks with address and oe_n held before sampling the byte
  // 3 -> 80ns @ 50MHz, enough for a 70ns part
  localparam int DLY = 3;

  typedef logic [QDW-1:0] word_t;     // qmem data word
  typedef logic [FDW-1:0] fbyte_t;    // one flash byte

  // sequencer states
  typedef enum logic [1:0] {
    IDLE,                             // wait for cs
    ACCESS,                           // flash selected, counting access time
    PUSH,                             // byte (or err item) offered downstream
    DONE                              // wait for the packer to answer qmem
  } seq_state_t;

endpackage

// ==== flash_byte_if.sv ====
//////////////////////////////////////////////////
// byte stream between sequencer, FIFO and packer
// valid/ready handshake, one item per transfer
//////////////////////////////////////////////////

interface flash_byte_if;

  import flash_pkg::*;

  logic   valid;                      // item present
  fbyte_t data;                       // flash byte, ignored on err items
  logic   last;                       // fourth byte of a word
  logic   err;                        // write refused, no data
  logic   ready;                      // consumer can take the item

  // item source side
  modport producer (
    output valid, data, last, err,
    input  ready
  );

  // item sink side
  modport consumer (
    input  valid, data, last, err,
    output ready
  );

endinterface

// ==== flash_seq.sv ====
//////////////////////////////////////////////////
// flash access sequencer
// turns one held qmem request into four timed byte
// reads of the NOR flash, or one err item for a write
//////////////////////////////////////////////////

module flash_seq (
  input  logic                     clk,
  input  logic                     rst_n,
  // held qmem request
  input  logic                     cs,
  input  logic                     we,
  input  logic [flash_pkg::QAW-1:0] adr,
  input  logic                     done,      // packer answered qmem
  // flash pins
  output logic [flash_pkg::FAW-1:0] fl_adr,
  output logic                     fl_ce_n,
  output logic                     fl_oe_n,
  output logic                     fl_rst_n,
  input  flash_pkg::fbyte_t        fl_dat_r,
  // byte stream out
  flash_byte_if.producer           bytes
);

  import flash_pkg::*;

  seq_state_t                 state;
  logic [$clog2(DLY+1)-1:0]   cnt;          // access time counter
  logic [1:0]                 idx;          // byte within the word

  logic start;                              // request accepted in IDLE
  logic cap;                                // access time over, sample flash
  logic adv;                                // byte taken by the FIFO

  assign start = (state == IDLE) && cs;
  assign cap   = (state == ACCESS) && (int'(cnt) == DLY);
  assign adv   = (state == PUSH) && bytes.ready;

  //////////////////////////////////////////////////
  // control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      cnt         <= '0;
      idx         <= '0;
      fl_ce_n     <= 1'b1;
      fl_oe_n     <= 1'b1;
      fl_rst_n    <= 1'b0;                  // flash held in reset with us
      bytes.valid <= 1'b0;
    end else begin
      fl_rst_n <= 1'b1;                     // released on first edge
      case (state)
        IDLE: begin
          if (start && we) begin
            state       <= PUSH;            // write: skip the flash entirely
            bytes.valid <= 1'b1;
          end else if (start) begin
            state   <= ACCESS;
            fl_ce_n <= 1'b0;
            fl_oe_n <= 1'b0;
            cnt     <= '0;
            idx     <= '0;
          end
        end
        ACCESS: begin
          if (cap) begin
            state       <= PUSH;
            fl_oe_n     <= 1'b1;            // ce_n stays low while we wait
            bytes.valid <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        PUSH: begin
          if (adv) begin
            bytes.valid <= 1'b0;
            if (bytes.last) begin
              state   <= DONE;
              fl_ce_n <= 1'b1;
            end else begin
              state   <= ACCESS;            // next byte of the word
              fl_oe_n <= 1'b0;
              cnt     <= '0;
              idx     <= idx + 1'b1;
            end
          end
        end
        DONE: if (done) state <= IDLE;      // request now answered
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // address and item payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (start) begin
      fl_adr     <= FAW'({adr[QAW-1:2], 2'b00}); // word aligned, low bits ignored
      bytes.err  <= we;
      bytes.last <= we;                     // err item ends the request
    end
    if (cap) begin
      bytes.data <= fl_dat_r;
      bytes.last <= (idx == 2'(BYTES_PER_WORD-1));
    end
    if (adv && !bytes.last)
      fl_adr[1:0] <= idx + 1'b1;            // step to next byte
  end

endmodule

// ==== flash_byte_fifo.sv ====
//////////////////////////////////////////////////
// small FIFO for byte items
// decouples flash timing from the word packer.
// DEPTH must be a power of two, at least 2
//////////////////////////////////////////////////

module flash_byte_fifo #(
  parameter int DEPTH = 4
) (
  input  logic           clk,
  input  logic           rst_n,
  flash_byte_if.consumer in_s,     // from sequencer
  flash_byte_if.producer out_s     // to packer
);

  import flash_pkg::*;

  logic [FDW+1:0]         mem [DEPTH];      // {err, last, data}
  logic [$clog2(DEPTH):0] wr_ptr;           // extra msb tells full from empty
  logic [$clog2(DEPTH):0] rd_ptr;
  logic                   full;
  logic                   empty;
  logic                   push;
  logic                   pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)]) &&
                 (wr_ptr[$clog2(DEPTH)-1:0] == rd_ptr[$clog2(DEPTH)-1:0]);

  assign push = in_s.valid && in_s.ready;
  assign pop  = out_s.valid && out_s.ready;

  assign in_s.ready  = !full;
  assign out_s.valid = !empty;               // valid the cycle after push

  // head item straight from storage
  assign {out_s.err, out_s.last, out_s.data} = mem[rd_ptr[$clog2(DEPTH)-1:0]];

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr[$clog2(DEPTH)-1:0]] <= {in_s.err, in_s.last, in_s.data};
  end

  // pointers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

// ==== word_assembler.sv ====
//////////////////////////////////////////////////
// word packer
// collects flash bytes big-endian into a qmem word
// and answers the request with ack, or err for writes
//////////////////////////////////////////////////

module word_assembler (
  input  logic              clk,
  input  logic              rst_n,
  flash_byte_if.consumer    bytes,    // from FIFO
  // qmem response
  output flash_pkg::word_t  dat_r,
  output logic              ack,
  output logic              err,
  output logic              done      // tells the sequencer we answered
);

  import flash_pkg::*;

  word_t sh;                          // partial word, first byte ends up on top
  logic  take;                        // item accepted this cycle

  // stall while a finished word (or err) is on the bus
  assign bytes.ready = !(ack || err);
  assign take        = bytes.valid && bytes.ready;
  assign done        = ack || err;    // same cycle as the qmem answer

  //////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (take && !bytes.err) begin
      sh <= {sh[QDW-FDW-1:0], bytes.data};            // shift in from the right
      if (bytes.last)
        dat_r <= {sh[QDW-FDW-1:0], bytes.data};       // complete word
    end
  end

  // qmem strobes, one cycle each
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
      err <= 1'b0;
    end else begin
      ack <= take && bytes.last && !bytes.err;
      err <= take && bytes.err;      // dat_r left as it was
    end
  end

endmodule

// ==== ctrl_flash.sv ====
//////////////////////////////////////////////////
// read-only boot ROM on a qmem slave port
// external 8 bit NOR flash, big-endian words,
// writes are refused with err
//////////////////////////////////////////////////

module ctrl_flash (
  // system
  input  logic                      clk,
  input  logic                      rst_n,
  // qmem slave
  input  logic                      cs,
  input  logic                      we,
  input  logic [flash_pkg::QAW-1:0] adr,
  input  logic [flash_pkg::QSW-1:0] sel,      // unused, ROM reads whole words
  input  flash_pkg::word_t          dat_w,    // unused, ROM is never written
  output flash_pkg::word_t          dat_r,
  output logic                      ack,
  output logic                      err,
  // flash pins
  output logic [flash_pkg::FAW-1:0] fl_adr,
  output logic                      fl_ce_n,
  output logic                      fl_oe_n,
  output logic                      fl_rst_n,
  input  flash_pkg::fbyte_t         fl_dat_r
);

  // sel and dat_w only kept for qmem port compatibility

  flash_byte_if seq_bytes ();         // sequencer -> FIFO
  flash_byte_if fifo_bytes ();        // FIFO -> packer

  logic done;                         // request answered

  flash_seq u_seq (
    .clk      (clk      ),
    .rst_n    (rst_n    ),
    .cs       (cs       ),
    .we       (we       ),
    .adr      (adr      ),
    .done     (done     ),
    .fl_adr   (fl_adr   ),
    .fl_ce_n  (fl_ce_n  ),
    .fl_oe_n  (fl_oe_n  ),
    .fl_rst_n (fl_rst_n ),
    .fl_dat_r (fl_dat_r ),
    .bytes    (seq_bytes)
  );

  flash_byte_fifo #(.DEPTH(4)) u_fifo (
    .clk      (clk       ),
    .rst_n    (rst_n     ),
    .in_s     (seq_bytes ),
    .out_s    (fifo_bytes)
  );

  word_assembler u_asm (
    .clk      (clk       ),
    .rst_n    (rst_n     ),
    .bytes    (fifo_bytes),
    .dat_r    (dat_r     ),
    .ack      (ack       ),
    .err      (err       ),
    .done     (done      )
  );

endmodule

// ==== ctrl_flash_checker.sv ====
//////////////////////////////////////////////////
// protocol assertions on the ctrl_flash pins
// bound into every ctrl_flash instance
//////////////////////////////////////////////////

module ctrl_flash_checker (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      cs,
  input logic                      ack,
  input logic                      err,
  input logic [flash_pkg::FAW-1:0] fl_adr,
  input logic                      fl_ce_n,
  input logic                      fl_oe_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // output enable only with the chip selected
  a_oe_needs_ce: assert property (@(posedge clk) disable iff (!rst_n)
    !fl_oe_n |-> !fl_ce_n) else $error("fl_oe_n low while fl_ce_n high");

  a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ack && err)) else $error("ack and err high together");

  // answer only to a held request
  a_resp_in_cs: assert property (@(posedge clk) disable iff (!rst_n)
    (ack || err) |-> cs) else $error("ack or err without cs");

  // address frozen during one byte access
  a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (!fl_oe_n && !$past(fl_oe_n)) |-> $stable(fl_adr))
    else $error("fl_adr moved while fl_oe_n low");

endmodule

bind ctrl_flash ctrl_flash_checker u_checker (
  .clk     (clk    ),
  .rst_n   (rst_n  ),
  .cs      (cs     ),
  .ack     (ack    ),
  .err     (err    ),
  .fl_adr  (fl_adr ),
  .fl_ce_n (fl_ce_n),
  .fl_oe_n (fl_oe_n)
);

// ==== tb_ctrl_flash.sv ====
//////////////////////////////////////////////////
// testbench for the flash boot-ROM controller
// combinational NOR flash model, a table of qmem
// requests applied in a loop, checked per request
//////////////////////////////////////////////////

module tb_ctrl_flash;

  timeunit 1ns;
  timeprecision 100ps;

  import flash_pkg::*;

  typedef enum logic [1:0] {R_NONE, R_ACK, R_ERR, R_BOTH} resp_t;  // {err, ack}

  localparam int NT      = 21;          // table entries
  localparam int TIMEOUT = 200;         // cycles per wait

  logic           clk = 1'b0;
  logic           rst_n;
  logic           cs;
  logic           we;
  logic [QAW-1:0] adr;
  logic [QSW-1:0] sel;
  word_t          dat_w;
  word_t          dat_r;
  logic           ack;
  logic           err;
  logic [FAW-1:0] fl_adr;
  logic           fl_ce_n;
  logic           fl_oe_n;
  logic           fl_rst_n;
  fbyte_t         fl_dat_r;

  // stimulus table
  string          t_name [NT];
  logic           t_we   [NT];
  logic [QAW-1:0] t_adr  [NT];
  resp_t          t_kind [NT];
  int             t_gap  [NT];          // idle cycles before the request
  int             nt     = 0;

  logic [31:0] lfsr   = 32'h5b93;
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;

  always #20 clk = ~clk;                // 40ns period

  ctrl_flash DUT (.*);

  //////////////////////////////////////////////////
  // flash model and expected words
  //////////////////////////////////////////////////

  function automatic fbyte_t model_byte(logic [FAW-1:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5a;
  endfunction

  assign fl_dat_r = (!fl_ce_n && !fl_oe_n) ? model_byte(fl_adr) : 8'hxx;

  // byte 0 of the word ends up on top
  function automatic word_t model_word(logic [QAW-1:0] a);
    word_t w = '0;
    for (int k = 0; k < BYTES_PER_WORD; k++)
      w[QDW-1-FDW*k -: FDW] = model_byte(FAW'({a[QAW-1:2], 2'(k)}));
    return w;
  endfunction

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);   // galois, right shift
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic resp_t resp_of(logic a, logic e);
    return resp_t'({e, a});
  endfunction

  //////////////////////////////////////////////////
  // compare tasks and helpers
  //////////////////////////////////////////////////

  task automatic check_word(string name, word_t exp, word_t got);
    if (got !== exp) begin
      $display("[ERROR] %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_resp(string name, resp_t exp, resp_t got);
    if (got !== exp) begin
      $display("[ERROR] %s: expected %s, got %s", name, exp.name(), got.name());
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic got);
    if (got !== exp) begin
      $display("[ERROR] %s: expected %b, got %b", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_fl_adr(string name, logic [FAW-1:0] exp, logic [FAW-1:0] got);
    if (got !== exp) begin
      $display("[ERROR] %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic add_entry(string name, logic w, logic [QAW-1:0] a, int gap);
    t_name[nt] = name;
    t_we[nt]   = w;
    t_adr[nt]  = a;
    t_kind[nt] = w ? R_ERR : R_ACK;     // ROM refuses every write
    t_gap[nt]  = gap;
    nt++;
  endtask

  task automatic report_test(string name, int e0);
    if (errors == e0) begin
      passed++;
      $display("[PASS] %s", name);
    end else begin
      failed++;
      $display("[FAIL] %s", name);
    end
  endtask

  task automatic next_drive();          // 2ns after the rising edge
    @(posedge clk);
    #2;
  endtask

  // sample at negedge until ack or err shows up
  task automatic wait_response(string name, logic [QAW-1:0] a, output resp_t r,
                               output bit ce_seen, output bit timed_out);
    bit adr_ok;

    r         = R_NONE;
    ce_seen   = 1'b0;
    timed_out = 1'b1;
    adr_ok    = 1'b1;
    for (int n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (!fl_ce_n) ce_seen = 1'b1;
      if (!fl_oe_n && adr_ok) begin     // upper bits never reach the model data
        adr_ok = (fl_adr[FAW-1:2] === a[QAW-1:2]);
        check_fl_adr({name, " fl_adr"}, FAW'({a[QAW-1:2], 2'b00}),
                     {fl_adr[FAW-1:2], 2'b00});
      end
      r = resp_of(ack, err);
      if (r != R_NONE) begin
        if (n == 0) begin               // still the previous strobe
          $display("%s: answer in the first cycle, previous strobe held too long", name);
          errors++;
        end
        timed_out = 1'b0;
        break;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    resp_t       r;
    bit          ce_seen;
    bit          tmo;
    int          e0;
    int          n;
    logic [31:0] rv;

    rst_n = 1'b0;
    cs    = 1'b0;
    we    = 1'b0;
    adr   = '0;
    sel   = '1;
    dat_w = '0;

    add_entry("rd_0",       1'b0, 22'h000000, 1);
    add_entry("rd_4",       1'b0, 22'h000004, 1);
    add_entry("rd_top",     1'b0, 22'h3ffffc, 1);
    add_entry("wr_refused", 1'b1, 22'h000010, 2);
    add_entry("b2b_a",      1'b0, 22'h000100, 1);
    add_entry("b2b_b",      1'b0, 22'h002468, 0);     // cs kept high from here
    add_entry("b2b_c",      1'b0, 22'h013570, 0);
    add_entry("b2b_wr",     1'b1, 22'h000020, 0);
    add_entry("b2b_d",      1'b0, 22'h000008, 0);
    add_entry("unalign_1",  1'b0, 22'h000203, 2);     // same word as 0x200
    add_entry("unalign_2",  1'b0, 22'h3fffff, 1);
    for (int k = 0; k < 10; k++) begin
      take_bits(QAW-2, rv);
      add_entry($sformatf("rnd_%0d", k), 1'b0, {rv[QAW-3:0], 2'b00}, 1);
    end

    // reset, 3 cycles
    e0 = errors;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_resp("reset resp", R_NONE, resp_of(ack, err));
    check_bit("reset fl_ce_n", 1'b1, fl_ce_n);
    check_bit("reset fl_oe_n", 1'b1, fl_oe_n);
    check_bit("reset fl_rst_n low", 1'b0, fl_rst_n);
    @(posedge clk);
    #2 rst_n = 1'b1;
    n = 0;
    while (fl_rst_n !== 1'b1 && n < 4) begin
      next_drive();
      n++;
    end
    check_bit("fl_rst_n on first edge", 1'b1, n == 1);
    report_test("reset", e0);

    for (int i = 0; i < nt; i++) begin
      e0 = errors;
      if (t_gap[i] > 0) cs = 1'b0;
      for (int g = 0; g < t_gap[i]; g++) begin
        @(negedge clk);
        check_resp({t_name[i], " idle"}, R_NONE, resp_of(ack, err));
        next_drive();
      end
      cs    = 1'b1;
      we    = t_we[i];
      adr   = t_adr[i];
      dat_w = t_we[i] ? (32'hc0de_0000 | 32'(i)) : '0;
      wait_response(t_name[i], t_adr[i], r, ce_seen, tmo);
      if (tmo) begin
        $display("%s: no ack or err within %0d cycles", t_name[i], TIMEOUT);
        errors++;
        report_test(t_name[i], e0);
        break;
      end
      check_resp(t_name[i], t_kind[i], r);
      if (t_kind[i] == R_ACK) check_word(t_name[i], model_word(t_adr[i]), dat_r);
      if (t_we[i]) check_bit({t_name[i], " fl_ce_n high"}, 1'b1, !ce_seen);
      report_test(t_name[i], e0);
      next_drive();                     // next request may start here
    end

    cs = 1'b0;
    @(negedge clk);
    check_resp("final idle", R_NONE, resp_of(ack, err));

    $display("tests: %0d passed, %0d failed, %0d check errors", passed, failed, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// ==== ctrl_flash.f ====
flash_pkg.sv
flash_byte_if.sv
flash_seq.sv
flash_byte_fifo.sv
word_assembler.sv
ctrl_flash.sv
ctrl_flash_checker.sv
tb_ctrl_flash.sv

// ==== Makefile ====
# Verilator run of the flash boot-ROM controller testbench
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_ctrl_flash
FLIST    = ctrl_flash.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failures found

.PHONY: sim clean

# build, run, then look for the fail message in the log
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$rc

clean:
	rm -rf $(OBJ_DIR) $(LOG)
